// File: Makefile
# Verilator build and run for the UDP echo responder testbench

VERILATOR ?= verilator
TOP       ?= tb_udp_echo
FILE_LIST ?= udp_echo_core.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR)

// File: dv/tb_clk_gen.sv
// ################################################
// Testbench clock and reset generator
// 125 MHz clock, reset held for two cycles
// ################################################
module tb_clk_gen (
    output logic clk_125mhz,
    output logic rst_125mhz
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;
    end

    initial begin
        rst_125mhz = 1'b1;
        repeat (2) @(posedge clk_125mhz);
        rst_125mhz <= 1'b0;
    end

endmodule

// File: dv/tb_udp_echo.sv
// ################################################
// Testbench for the UDP echo responder
// Frame stimulus from an LFSR, scoreboard for the
// reply addresses, payload, error flag and length
// ################################################
`include "udp_echo_defs.svh"

module tb_udp_echo;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HDR = `UDP_ECHO_HDR_BYTES;
    localparam int WAIT_LIMIT = 20000;
    localparam logic [47:0] LOCAL_MAC = `UDP_ECHO_LOCAL_MAC;
    localparam logic [31:0] LOCAL_IP = `UDP_ECHO_LOCAL_IP;

    logic        clk_125mhz;
    logic        rst_125mhz;
    logic [7:0]  in_tdata;
    logic        in_tvalid;
    logic        in_tready;
    logic        in_tlast;
    logic        in_tuser;
    logic [7:0]  out_tdata;
    logic        out_tvalid;
    logic        out_tready = 1'b1;
    logic        out_tlast;
    logic        out_tuser;
    logic        led;
    logic [31:0] lfsr_q = 32'h58705204;
    logic        stall_en = 1'b0;
    logic        ready_next = 1'b1;
    logic [7:0]  exp_bytes[$];
    logic        exp_users[$];
    logic [95:0] exp_peers[$];
    int          exp_lens[$];
    int          match_count = 0;
    int          reply_count = 0;
    int          out_off = 0;

    tb_clk_gen clk_gen0 (.clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz));

    udp_echo_core dut0 (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .in_tdata(in_tdata), .in_tvalid(in_tvalid), .in_tready(in_tready),
        .in_tlast(in_tlast), .in_tuser(in_tuser),
        .out_tdata(out_tdata), .out_tvalid(out_tvalid), .out_tready(out_tready),
        .out_tlast(out_tlast), .out_tuser(out_tuser), .led(led)
    );

    // Galois LFSR, stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h80200003 : lfsr_q >> 1;
        end
        return bits;
    endfunction

    // Even frames match, odd ones cycle through the four reject kinds
    function automatic int frame_kind(input int i);
        return (i % 2 == 0) ? 0 : 1 + (i / 2) % 4;
    endfunction

    // Reply bytes addressed back to the sender, flag in bit 8
    // Sender record is MAC, IP and port from the top bits down
    function automatic logic [8:0] peer_byte(input logic [95:0] peer, input int off);
        case (off) inside
            [0:5]:   return {1'b1, peer[95 - 8*off -: 8]};
            [30:33]: return {1'b1, peer[47 - 8*(off - 30) -: 8]};
            [36:37]: return {1'b1, peer[15 - 8*(off - 36) -: 8]};
            default: return 9'h000;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            abort_run($sformatf("FAIL time=%0t %s got 0x%0h expected 0x%0h",
                $time, name, got, expected));
        end
    endtask

    task automatic drive_byte(input logic [7:0] data, input logic last, input logic user);
        int waited;
        waited = 0;
        if (take_bits(2) == 32'd0) begin
            in_tvalid = 1'b0;
            @(negedge clk_125mhz);
        end
        in_tdata = data;
        in_tlast = last;
        in_tuser = user;
        in_tvalid = 1'b1;
        while (!in_tready) begin
            @(negedge clk_125mhz);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Timed out waiting for in_tready");
            end
        end
        @(negedge clk_125mhz);
    endtask

    // kind 0 matches, 1 wrong port, 2 wrong ethertype, 3 wrong protocol, 4 wrong IP
    task automatic send_frame(input int kind);
        logic [8*HDR-1:0] hdr_bits;
        logic [7:0]       payload[$];
        logic [47:0]      src_mac;
        logic [31:0]      src_ip;
        logic [15:0]      src_port;
        logic [15:0]      ethertype;
        logic [7:0]       proto;
        logic [31:0]      dst_ip;
        logic [15:0]      dst_port;
        logic             pl_err;
        int               pl_len;
        pl_len = 1 + int'(take_bits(6));
        src_mac = {16'(take_bits(16)), take_bits(32)};
        src_ip = take_bits(32);
        src_port = 16'(take_bits(16));
        ethertype = (kind == 2) ? 16'h86dd : 16'h0800;
        proto = (kind == 3) ? 8'd6 : 8'd17;
        dst_ip = (kind == 4) ? LOCAL_IP ^ 32'h1 : LOCAL_IP;
        dst_port = (kind == 1) ? `UDP_ECHO_PORT + 16'd1 : `UDP_ECHO_PORT;
        hdr_bits = {LOCAL_MAC, src_mac, ethertype,
                    8'h45, 8'h00, 16'(pl_len + 28), 16'h0000, 16'h4000, 8'd64, proto,
                    16'h0000, src_ip, dst_ip,
                    src_port, dst_port, 16'(pl_len + 8), 16'h0000};
        for (int i = 0; i < pl_len; i++) begin
            payload.push_back(8'(take_bits(8)));
        end
        // Error flag rides on the last beat of the frame
        pl_err = take_bits(1) == 32'd1;
        if (kind == 0) begin
            foreach (payload[i]) begin
                exp_bytes.push_back(payload[i]);
                exp_users.push_back(pl_err && i == pl_len - 1);
            end
            exp_peers.push_back({src_mac, src_ip, src_port});
            exp_lens.push_back(pl_len);
            match_count++;
        end
        for (int i = 0; i < HDR; i++) begin
            drive_byte(hdr_bits[8*(HDR-1-i) +: 8], 1'b0, 1'b0);
        end
        for (int i = 0; i < pl_len; i++) begin
            drive_byte(payload[i], i == pl_len - 1, pl_err && i == pl_len - 1);
        end
        in_tvalid = 1'b0;
        in_tuser = 1'b0;
    endtask

    // Stall pattern drawn on the rising edge, applied on the falling edge
    always @(posedge clk_125mhz) begin
        if (stall_en) begin
            ready_next = take_bits(1) == 32'd1;
        end
    end

    always @(negedge clk_125mhz) begin
        out_tready <= ready_next;
    end

    always @(negedge clk_125mhz) begin
        if (dut0.assert0.fail_count != 0) begin
            abort_run("An assertion on the reply stream failed");
        end
    end

    // Sender addresses in the reply header, then the payload bytes
    always @(posedge clk_125mhz) begin
        logic [8:0] hdr_exp;
        if (!rst_125mhz && out_tvalid && out_tready) begin
            if (out_off < HDR) begin
                if (exp_peers.size() == 0) begin
                    abort_run("Reply started with no matching frame sent");
                end else begin
                    hdr_exp = peer_byte(exp_peers[0], out_off);
                    if (hdr_exp[8]) begin
                        check_value("out_tdata", int'(out_tdata), int'(hdr_exp[7:0]));
                    end
                end
            end else if (exp_bytes.size() == 0) begin
                abort_run("Reply carried more payload bytes than were sent");
            end else begin
                check_value("out_tdata", int'(out_tdata), int'(exp_bytes.pop_front()));
                check_value("out_tuser", int'(out_tuser), int'(exp_users.pop_front()));
            end
            if (out_tlast) begin
                if (exp_lens.size() == 0) begin
                    abort_run("Reply arrived with no matching frame sent");
                end else begin
                    check_value("reply length", out_off + 1, HDR + exp_lens.pop_front());
                    exp_peers.delete(0);
                end
                reply_count++;
                out_off = 0;
            end else begin
                out_off++;
            end
        end
    end

    initial begin
        int waited;
        in_tdata = 8'h00;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        waited = 0;
        @(negedge clk_125mhz);
        while (rst_125mhz) begin
            @(negedge clk_125mhz);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Reset never released");
            end
        end
        check_value("out_tvalid", int'(out_tvalid), 0);
        check_value("in_tready", int'(in_tready), 1);
        check_value("led", int'(led), 0);
        for (int i = 0; i < 16; i++) begin
            send_frame(frame_kind(i));
        end
        // Random output stalls from here on
        stall_en = 1'b1;
        for (int i = 16; i < 48; i++) begin
            send_frame(frame_kind(i));
        end
        waited = 0;
        while (reply_count < match_count) begin
            @(negedge clk_125mhz);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Timed out waiting for the remaining replies");
            end
        end
        if (exp_bytes.size() == 0 && reply_count == match_count) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run("Expected payload bytes left over after the last reply");
        end
    end

endmodule

// File: dv/udp_echo_assert.sv
// ################################################
// Reply stream assertions, bound to the core
// Fixed header fields, checksum, lengths,
// handshake stability and LED
// ################################################
`include "udp_echo_defs.svh"

module udp_echo_assert (
    input logic       clk_125mhz,
    input logic       rst_125mhz,
    input logic [7:0] out_tdata,
    input logic       out_tvalid,
    input logic       out_tready,
    input logic       out_tlast,
    input logic       led
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [47:0] LOCAL_MAC = `UDP_ECHO_LOCAL_MAC;
    localparam logic [31:0] LOCAL_IP = `UDP_ECHO_LOCAL_IP;
    localparam logic [15:0] ECHO_PORT = `UDP_ECHO_PORT;

    int          fail_count = 0;
    logic [11:0] off_q;
    logic [7:0]  hi_q;
    logic [15:0] ip_len_q;
    logic [15:0] udp_len_q;
    logic [19:0] sum_q;
    logic        first_bit_q;
    logic        fire;
    logic [15:0] word;
    logic [19:0] sum_next;
    logic [16:0] fold1;
    logic [15:0] fold2;
    logic [8:0]  fixed;

    // Bytes whose value is the same in every reply, flag in bit 8
    function automatic logic [8:0] fixed_byte(input int off);
        case (off) inside
            [6:11]:  return {1'b1, LOCAL_MAC[8*(11-off) +: 8]};
            12:      return {1'b1, 8'h08};
            13:      return {1'b1, 8'h00};
            22:      return {1'b1, `UDP_ECHO_TTL};
            23:      return {1'b1, 8'd17};
            [26:29]: return {1'b1, LOCAL_IP[8*(29-off) +: 8]};
            34:      return {1'b1, ECHO_PORT[15:8]};
            35:      return {1'b1, ECHO_PORT[7:0]};
            default: return 9'h000;
        endcase
    endfunction

    assign fire = out_tvalid && out_tready;
    assign word = {hi_q, out_tdata};
    assign sum_next = sum_q + 20'(word);
    assign fold1 = 17'(sum_next[15:0]) + 17'(sum_next[19:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);
    assign fixed = fixed_byte(int'(off_q));

    // Byte offset within the reply and captured header words
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            off_q <= '0;
            sum_q <= '0;
        end else if (fire) begin
            off_q <= out_tlast ? 12'd0 : off_q + 12'd1;
            if (!off_q[0]) begin
                hi_q <= out_tdata;
            end
            if (off_q == 12'd0) begin
                sum_q <= '0;
            end
            // IPv4 header spans offsets 14 to 33
            if (off_q[0] && off_q >= 12'd15 && off_q <= 12'd33) begin
                sum_q <= sum_next;
            end
            if (off_q == 12'd17) begin
                ip_len_q <= word;
            end
            if (off_q == 12'd39) begin
                udp_len_q <= word;
            end
            if (off_q == 12'd42) begin
                first_bit_q <= out_tdata[0];
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk_125mhz) rst_125mhz |=> !out_tvalid)
        else begin
            fail_count = fail_count + 1;
            $error("out_tvalid high after reset");
        end

    a_stall_stable: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) && $stable(out_tlast))
        else begin
            fail_count = fail_count + 1;
            $error("stalled beat changed");
        end

    a_fixed_field: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        out_tvalid && fixed[8] |-> out_tdata == fixed[7:0])
        else begin
            fail_count = fail_count + 1;
            $error("header byte %0d wrong", off_q);
        end

    a_hdr_no_last: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        out_tvalid && off_q < 12'd42 |-> !out_tlast)
        else begin
            fail_count = fail_count + 1;
            $error("tlast inside reply header");
        end

    a_ip_len: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        fire && off_q == 12'd39 |-> ip_len_q == word + 16'd20)
        else begin
            fail_count = fail_count + 1;
            $error("IP total length mismatch");
        end

    a_ip_csum: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        fire && off_q == 12'd33 |-> fold2 == 16'hffff)
        else begin
            fail_count = fail_count + 1;
            $error("IPv4 header checksum wrong");
        end

    a_reply_len: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        fire && out_tlast |-> 16'(off_q) + 16'd1 == udp_len_q + 16'd34)
        else begin
            fail_count = fail_count + 1;
            $error("reply length mismatch");
        end

    a_led: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        fire && out_tlast |=> led == first_bit_q)
        else begin
            fail_count = fail_count + 1;
            $error("led does not follow payload");
        end

endmodule

bind udp_echo_core udp_echo_assert assert0 (
    .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
    .out_tdata(out_tdata), .out_tvalid(out_tvalid), .out_tready(out_tready),
    .out_tlast(out_tlast), .led(led)
);

// File: include/udp_echo_defs.svh
// ################################################
// Build-time constants for the UDP echo responder
// Local addresses, echo port, header size, TTL
// and FIFO depths
// ################################################
`ifndef UDP_ECHO_DEFS_SVH
`define UDP_ECHO_DEFS_SVH

// Local station addresses
`define UDP_ECHO_LOCAL_MAC 48'h02_00_00_00_00_00
`define UDP_ECHO_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// UDP port answered by the responder
`define UDP_ECHO_PORT 16'd1234

// Ethernet 14 + IPv4 20 + UDP 8
`define UDP_ECHO_HDR_BYTES 42

// TTL placed in every reply
`define UDP_ECHO_TTL 8'd64

// Queue depths in entries
`define UDP_ECHO_PAYLOAD_DEPTH 2048
`define UDP_ECHO_HDR_DEPTH 4

`endif

// File: src/stream_fifo.sv
// ################################################
// Valid/ready FIFO with a registered output
// Entry type and depth set by parameters
// ################################################
module stream_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 16
) (
    input  logic   clk_125mhz,
    input  logic   rst_125mhz,
    input  logic   wr_valid,
    output logic   wr_ready,
    input  entry_t wr_data,
    output logic   rd_valid,
    input  logic   rd_ready,
    output entry_t rd_data
);
    localparam int AW = $clog2(DEPTH);

    entry_t        mem [DEPTH];
    logic [AW:0]   wr_ptr_q;
    logic [AW:0]   rd_ptr_q;
    logic          mem_empty;
    logic          mem_full;
    logic          wr_fire;
    logic          load_out;
    logic          bypass;
    logic          mem_wr;
    logic          mem_rd;

    assign mem_empty = wr_ptr_q == rd_ptr_q;
    assign mem_full = (wr_ptr_q ^ rd_ptr_q) == {1'b1, {AW{1'b0}}};
    assign wr_ready = !mem_full;
    assign wr_fire = wr_valid && wr_ready;

    // Output register takes a new entry when empty or being read
    assign load_out = !rd_valid || rd_ready;
    assign bypass = wr_fire && mem_empty && load_out;
    assign mem_wr = wr_fire && !bypass;
    assign mem_rd = load_out && !mem_empty;

    always_ff @(posedge clk_125mhz) begin
        if (mem_wr) begin
            mem[wr_ptr_q[AW-1:0]] <= wr_data;
        end
        if (mem_rd) begin
            rd_data <= mem[rd_ptr_q[AW-1:0]];
        end else if (bypass) begin
            rd_data <= wr_data;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (load_out) begin
                rd_valid <= mem_rd || bypass;
            end
        end
    end

endmodule

// File: src/udp_echo_core.sv
// ################################################
// UDP echo responder top level
// Parser, port filter, header and payload FIFOs,
// reply builder
// ################################################
`include "udp_echo_defs.svh"

module udp_echo_core
    import udp_echo_pkg::*;
(
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,
    input  logic [7:0] in_tdata,
    input  logic       in_tvalid,
    output logic       in_tready,
    input  logic       in_tlast,
    input  logic       in_tuser,
    output logic [7:0] out_tdata,
    output logic       out_tvalid,
    input  logic       out_tready,
    output logic       out_tlast,
    output logic       out_tuser,
    output logic       led
);
    // Parser to filter
    logic       hdr_valid;
    logic       hdr_ready;
    udp_hdr_t   hdr;
    logic       pl_valid;
    logic       pl_ready;
    byte_beat_t pl;

    // FIFO write and read sides
    logic       hdr_wr_valid;
    logic       hdr_wr_ready;
    logic       pl_wr_valid;
    logic       pl_wr_ready;
    logic       hdr_rd_valid;
    logic       hdr_rd_ready;
    udp_hdr_t   hdr_rd;
    logic       pl_rd_valid;
    logic       pl_rd_ready;
    byte_beat_t pl_rd;

    udp_hdr_parser parser0 (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .in_tdata(in_tdata), .in_tvalid(in_tvalid), .in_tready(in_tready),
        .in_tlast(in_tlast), .in_tuser(in_tuser),
        .hdr_valid(hdr_valid), .hdr_ready(hdr_ready), .hdr(hdr),
        .pl_valid(pl_valid), .pl_ready(pl_ready), .pl(pl)
    );

    udp_port_filter filter0 (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .hdr_valid(hdr_valid), .hdr_ready(hdr_ready), .hdr(hdr),
        .pl_valid(pl_valid), .pl_ready(pl_ready), .pl(pl),
        .hdr_wr_valid(hdr_wr_valid), .hdr_wr_ready(hdr_wr_ready),
        .pl_wr_valid(pl_wr_valid), .pl_wr_ready(pl_wr_ready)
    );

    stream_fifo #(.entry_t(udp_hdr_t), .DEPTH(`UDP_ECHO_HDR_DEPTH)) hdr_fifo (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .wr_valid(hdr_wr_valid), .wr_ready(hdr_wr_ready), .wr_data(hdr),
        .rd_valid(hdr_rd_valid), .rd_ready(hdr_rd_ready), .rd_data(hdr_rd)
    );

    stream_fifo #(.entry_t(byte_beat_t), .DEPTH(`UDP_ECHO_PAYLOAD_DEPTH)) pl_fifo (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .wr_valid(pl_wr_valid), .wr_ready(pl_wr_ready), .wr_data(pl),
        .rd_valid(pl_rd_valid), .rd_ready(pl_rd_ready), .rd_data(pl_rd)
    );

    udp_reply_builder builder0 (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .hdr_valid(hdr_rd_valid), .hdr_ready(hdr_rd_ready), .hdr(hdr_rd),
        .pl_valid(pl_rd_valid), .pl_ready(pl_rd_ready), .pl(pl_rd),
        .out_tdata(out_tdata), .out_tvalid(out_tvalid), .out_tready(out_tready),
        .out_tlast(out_tlast), .out_tuser(out_tuser), .led(led)
    );

endmodule

// File: src/udp_echo_pkg.sv
// ################################################
// Shared types for the UDP echo responder
// Address and port types, stream beat, header record
// ################################################
package udp_echo_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // One byte of a stream with its framing bits
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } byte_beat_t;

    // Fields of a received datagram that the reply needs
    typedef struct packed {
        mac_addr_t   src_mac;
        ip_addr_t    src_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] udp_len;
    } udp_hdr_t;

endpackage

// File: src/udp_hdr_parser.sv
// ################################################
// Ethernet, IPv4 and UDP header parser
// Checks ethertype, IHL, protocol and destination IP,
// emits a header record then the payload stream
// ################################################
`include "udp_echo_defs.svh"

module udp_hdr_parser
    import udp_echo_pkg::*;
(
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,
    input  logic [7:0] in_tdata,
    input  logic       in_tvalid,
    output logic       in_tready,
    input  logic       in_tlast,
    input  logic       in_tuser,
    output logic       hdr_valid,
    input  logic       hdr_ready,
    output udp_hdr_t   hdr,
    output logic       pl_valid,
    input  logic       pl_ready,
    output byte_beat_t pl
);
    localparam logic [5:0] HDR_LAST = 6'(`UDP_ECHO_HDR_BYTES - 1);
    localparam ip_addr_t LOCAL_IP = `UDP_ECHO_LOCAL_IP;

    typedef enum logic [1:0] {ST_HDR, ST_HDR_OUT, ST_PAYLOAD, ST_DROP} state_t;

    state_t      state_q;
    logic [5:0]  byte_cnt_q;
    logic [7:0]  type_hi_q;
    logic [23:0] dst_ip_q;
    mac_addr_t   src_mac_q;
    ip_addr_t    src_ip_q;
    udp_port_t   src_port_q;
    udp_port_t   dst_port_q;
    logic [15:0] udp_len_q;
    logic        in_fire;
    logic        hdr_bad;

    always_comb begin
        case (state_q)
            ST_HDR, ST_DROP: in_tready = 1'b1;
            ST_PAYLOAD:      in_tready = !pl_valid || pl_ready;
            default:         in_tready = 1'b0;
        endcase
    end

    assign in_fire = in_tvalid && in_tready;

    // Checks fire on the byte that completes each field
    always_comb begin
        case (byte_cnt_q)
            6'd13:   hdr_bad = {type_hi_q, in_tdata} != 16'h0800;
            6'd14:   hdr_bad = in_tdata != 8'h45;
            6'd23:   hdr_bad = in_tdata != 8'd17;
            6'd33:   hdr_bad = {dst_ip_q, in_tdata} != LOCAL_IP;
            default: hdr_bad = 1'b0;
        endcase
    end

    // Field capture by byte offset
    always_ff @(posedge clk_125mhz) begin
        if (state_q == ST_HDR && in_fire) begin
            case (byte_cnt_q) inside
                [6'd6:6'd11]:  src_mac_q <= {src_mac_q[39:0], in_tdata};
                6'd12:         type_hi_q <= in_tdata;
                [6'd26:6'd29]: src_ip_q <= {src_ip_q[23:0], in_tdata};
                [6'd30:6'd32]: dst_ip_q <= {dst_ip_q[15:0], in_tdata};
                [6'd34:6'd35]: src_port_q <= {src_port_q[7:0], in_tdata};
                [6'd36:6'd37]: dst_port_q <= {dst_port_q[7:0], in_tdata};
                [6'd38:6'd39]: udp_len_q <= {udp_len_q[7:0], in_tdata};
                default: ;
            endcase
        end
        if (state_q == ST_PAYLOAD && in_fire) begin
            pl <= '{data: in_tdata, last: in_tlast, user: in_tuser};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state_q <= ST_HDR;
            byte_cnt_q <= '0;
            hdr_valid <= 1'b0;
            pl_valid <= 1'b0;
        end else begin
            if (pl_valid && pl_ready) begin
                pl_valid <= 1'b0;
            end
            case (state_q)
                ST_HDR: begin
                    if (in_fire) begin
                        byte_cnt_q <= byte_cnt_q + 6'd1;
                        if (in_tlast) begin
                            // Frame ended inside the header
                            byte_cnt_q <= '0;
                        end else if (hdr_bad) begin
                            state_q <= ST_DROP;
                        end else if (byte_cnt_q == HDR_LAST) begin
                            state_q <= ST_HDR_OUT;
                            hdr_valid <= 1'b1;
                        end
                    end
                end
                ST_HDR_OUT: begin
                    if (hdr_ready) begin
                        hdr_valid <= 1'b0;
                        byte_cnt_q <= '0;
                        state_q <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (in_fire) begin
                        pl_valid <= 1'b1;
                        if (in_tlast) begin
                            state_q <= ST_HDR;
                        end
                    end
                end
                default: begin
                    // Swallow the rest of a rejected frame
                    if (in_fire && in_tlast) begin
                        byte_cnt_q <= '0;
                        state_q <= ST_HDR;
                    end
                end
            endcase
        end
    end

    assign hdr = '{src_mac: src_mac_q, src_ip: src_ip_q, src_port: src_port_q,
                   dst_port: dst_port_q, udp_len: udp_len_q};

endmodule

// File: src/udp_port_filter.sv
// ################################################
// Destination port filter
// Steers echo datagrams to the FIFOs and
// discards all others
// ################################################
`include "udp_echo_defs.svh"

module udp_port_filter
    import udp_echo_pkg::*;
(
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,
    input  logic       hdr_valid,
    output logic       hdr_ready,
    input  udp_hdr_t   hdr,
    input  logic       pl_valid,
    output logic       pl_ready,
    input  byte_beat_t pl,
    output logic       hdr_wr_valid,
    input  logic       hdr_wr_ready,
    output logic       pl_wr_valid,
    input  logic       pl_wr_ready
);
    logic match;
    logic pass_q;
    logic drop_q;
    logic idle;

    assign match = hdr.dst_port == `UDP_ECHO_PORT;
    assign idle = !pass_q && !drop_q;

    // A new header is taken only once the previous datagram is finished
    assign hdr_wr_valid = hdr_valid && idle && match;
    assign hdr_ready = idle && (hdr_wr_ready || !match);

    assign pl_wr_valid = pl_valid && pass_q;
    assign pl_ready = (pass_q && pl_wr_ready) || drop_q;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            pass_q <= 1'b0;
            drop_q <= 1'b0;
        end else if (hdr_valid && hdr_ready) begin
            pass_q <= match;
            drop_q <= !match;
        end else if (pl_valid && pl_ready && pl.last) begin
            pass_q <= 1'b0;
            drop_q <= 1'b0;
        end
    end

endmodule

// File: src/udp_reply_builder.sv
// ################################################
// UDP echo reply builder
// Serializes the 42-byte reply header with its
// IPv4 checksum, appends the payload, drives the LED
// ################################################
`include "udp_echo_defs.svh"

module udp_reply_builder
    import udp_echo_pkg::*;
(
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,
    input  logic       hdr_valid,
    output logic       hdr_ready,
    input  udp_hdr_t   hdr,
    input  logic       pl_valid,
    output logic       pl_ready,
    input  byte_beat_t pl,
    output logic [7:0] out_tdata,
    output logic       out_tvalid,
    input  logic       out_tready,
    output logic       out_tlast,
    output logic       out_tuser,
    output logic       led
);
    localparam int HDR_BYTES = `UDP_ECHO_HDR_BYTES;
    localparam logic [5:0] HDR_LAST = 6'(HDR_BYTES - 1);
    localparam mac_addr_t LOCAL_MAC = `UDP_ECHO_LOCAL_MAC;
    localparam ip_addr_t LOCAL_IP = `UDP_ECHO_LOCAL_IP;
    localparam logic [7:0] TTL = `UDP_ECHO_TTL;
    localparam logic [7:0] PROTO_UDP = 8'd17;
    // Don't-fragment flag set, offset zero
    localparam logic [15:0] FLAGS_DF = 16'h4000;

    typedef enum logic [1:0] {ST_IDLE, ST_CSUM, ST_HDR, ST_PAYLOAD} state_t;

    state_t                 state_q;
    udp_hdr_t               hdr_q;
    logic [5:0]             byte_cnt_q;
    logic [15:0]            ip_len;
    logic [19:0]            csum_sum;
    logic [16:0]            csum_fold;
    logic [15:0]            csum_q;
    logic [8*HDR_BYTES-1:0] reply_hdr;
    logic                   first_q;
    logic                   led_q;

    assign ip_len = hdr_q.udp_len + 16'd20;

    // Sum of the header words with the checksum field taken as zero
    assign csum_sum = 20'h04500 + 20'(ip_len) + 20'(FLAGS_DF) + 20'({TTL, PROTO_UDP})
        + 20'(LOCAL_IP[31:16]) + 20'(LOCAL_IP[15:0])
        + 20'(hdr_q.src_ip[31:16]) + 20'(hdr_q.src_ip[15:0]);
    assign csum_fold = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);

    // Reply header, first byte on the wire in the top bits
    assign reply_hdr = {
        hdr_q.src_mac, LOCAL_MAC, 16'h0800,
        8'h45, 8'h00, ip_len, 16'h0000, FLAGS_DF, TTL, PROTO_UDP, csum_q,
        LOCAL_IP, hdr_q.src_ip,
        hdr_q.dst_port, hdr_q.src_port, hdr_q.udp_len, 16'h0000
    };

    always_comb begin
        out_tvalid = 1'b0;
        out_tdata = 8'h00;
        out_tlast = 1'b0;
        out_tuser = 1'b0;
        pl_ready = 1'b0;
        case (state_q)
            ST_HDR: begin
                out_tvalid = 1'b1;
                out_tdata = reply_hdr[8*(HDR_BYTES - 1 - int'(byte_cnt_q)) +: 8];
            end
            ST_PAYLOAD: begin
                out_tvalid = pl_valid;
                out_tdata = pl.data;
                out_tlast = pl.last;
                out_tuser = pl.user;
                pl_ready = out_tready;
            end
            default: ;
        endcase
    end

    // Record leaves the FIFO with the last payload beat
    assign hdr_ready = state_q == ST_PAYLOAD && pl_valid && out_tready && pl.last;

    always_ff @(posedge clk_125mhz) begin
        if (state_q == ST_IDLE && hdr_valid) begin
            hdr_q <= hdr;
        end
        if (state_q == ST_CSUM) begin
            csum_q <= ~(csum_fold[15:0] + 16'(csum_fold[16]));
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state_q <= ST_IDLE;
            byte_cnt_q <= '0;
            first_q <= 1'b0;
            led_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (hdr_valid) begin
                        state_q <= ST_CSUM;
                    end
                end
                ST_CSUM: begin
                    byte_cnt_q <= '0;
                    state_q <= ST_HDR;
                end
                ST_HDR: begin
                    if (out_tready) begin
                        byte_cnt_q <= byte_cnt_q + 6'd1;
                        if (byte_cnt_q == HDR_LAST) begin
                            first_q <= 1'b1;
                            state_q <= ST_PAYLOAD;
                        end
                    end
                end
                default: begin
                    if (pl_valid && out_tready) begin
                        first_q <= 1'b0;
                        // LED follows the first payload byte
                        if (first_q) begin
                            led_q <= pl.data[0];
                        end
                        if (pl.last) begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    assign led = led_q;

endmodule

// File: udp_echo_core.f
+incdir+include
src/udp_echo_pkg.sv
src/stream_fifo.sv
src/udp_hdr_parser.sv
src/udp_port_filter.sv
src/udp_reply_builder.sv
src/udp_echo_core.sv
dv/udp_echo_assert.sv
dv/tb_clk_gen.sv
dv/tb_udp_echo.sv
